// File: Bender.yml
package:
  name: vic_register_file

sources:
  - files:
      - rtl/vic_pkg.sv
      - rtl/phase_timer.sv
      - rtl/bus_cycle_fsm.sv
      - rtl/ctrl_regs.sv
      - rtl/video_ram.sv
      - rtl/vram_port.sv
      - rtl/vic_register_file.sv
  - target: test
    files:
      - tb/vic_register_file_checker.sv
      - tb/tb_vic_register_file.sv

// File: rtl/bus_cycle_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_fsm (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_pkg::phase_t      phase,
    input  logic                 ras,
    input  logic                 ce,
    input  logic                 rw,
    input  logic                 aec,
    input  vic_pkg::reg_addr_t   adi,
    input  vic_pkg::byte_t       dbi,
    output vic_pkg::reg_access_t acc
);
    import vic_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LATCHED,
        DONE
    } state_t;

    state_t    state;
    reg_addr_t addr_q;
    logic      latch_now;
    logic      rd_now;
    logic      wr_now;
    logic      cycle_end;

    assign latch_now = state == IDLE && phase.phi_high && !ras;
    assign rd_now    = state == LATCHED && phase.phi_high && aec && !ce && rw;
    // writes land on the data-valid strobe only
    assign wr_now    = state == LATCHED && phase.phi_high && phase.dav && !ce && !rw;
    assign cycle_end = !phase.phi_high && phase.dav_plus_1;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            state <= IDLE;
        end else if (cycle_end) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (latch_now) begin
                        state <= LATCHED;
                    end
                end
                LATCHED: begin
                    if (rd_now || wr_now) begin
                        state <= DONE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (latch_now) begin
            addr_q <= adi;
        end
    end

    assign acc = '{rd: rd_now, wr: wr_now, addr: addr_q, data: dbi};

endmodule

`default_nettype wire

// File: rtl/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_pkg::reg_access_t acc,
    input  vic_pkg::byte_t       rd_data,
    input  logic                 rd_valid,
    input  logic                 raster_msb,
    output vic_pkg::vic_ctrl_t   ctrl,
    output vic_pkg::ext_flags_u  ext_flags,
    output vic_pkg::byte_t       dbo
);
    import vic_pkg::*;

    ext_flags_u wr_u;
    logic [1:0] unlock_cnt;
    logic       activated;
    byte_t      expected_key;
    byte_t      rd_value;

    assign wr_u = acc.data;

    // next byte of the unlock sequence
    always_comb begin
        case (unlock_cnt)
            2'd0:    expected_key = KEY_V;
            2'd1:    expected_key = KEY_I;
            2'd2:    expected_key = KEY_C;
            default: expected_key = KEY_2;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl       <= '0;
            ext_flags  <= '0;
            unlock_cnt <= 2'd0;
            activated  <= 1'b0;
        end else if (acc.wr) begin
            case (acc.addr)
                REG_SCREEN_CONTROL_1: begin
                    // bit 7 was raster compare, not kept
                    ctrl.yscroll <= acc.data[2:0];
                    ctrl.rsel    <= acc.data[3];
                    ctrl.den     <= acc.data[4];
                    ctrl.bmm     <= acc.data[5];
                    ctrl.ecm     <= acc.data[6];
                end
                REG_SCREEN_CONTROL_2: begin
                    ctrl.xscroll <= acc.data[2:0];
                    ctrl.csel    <= acc.data[3];
                    ctrl.mcm     <= acc.data[4];
                    ctrl.res     <= acc.data[5];
                end
                REG_MEMORY_SETUP: begin
                    ctrl.cb <= acc.data[3:1];
                    ctrl.vm <= acc.data[7:4];
                end
                REG_BORDER_COLOR:       ctrl.ec  <= acc.data[3:0];
                REG_BACKGROUND_COLOR_0: ctrl.b0c <= acc.data[3:0];
                REG_BACKGROUND_COLOR_1: ctrl.b1c <= acc.data[3:0];
                REG_BACKGROUND_COLOR_2: ctrl.b2c <= acc.data[3:0];
                REG_BACKGROUND_COLOR_3: ctrl.b3c <= acc.data[3:0];
                VMEM_FLAGS: begin
                    if (activated) begin
                        ext_flags <= wr_u;
                    end else if (wr_u.key == expected_key) begin
                        if (unlock_cnt == 2'd3) begin
                            activated <= 1'b1;
                        end else begin
                            unlock_cnt <= unlock_cnt + 2'd1;
                        end
                    end else begin
                        // wrong byte restarts the sequence
                        unlock_cnt <= 2'd0;
                    end
                end
                default: ;
            endcase
        end
    end

    // unused bits read back as ones
    always_comb begin
        rd_value = 8'hFF;
        case (acc.addr)
            REG_SCREEN_CONTROL_1:
                rd_value = {raster_msb, ctrl.ecm, ctrl.bmm, ctrl.den, ctrl.rsel, ctrl.yscroll};
            REG_SCREEN_CONTROL_2:
                rd_value = {2'b11, ctrl.res, ctrl.mcm, ctrl.csel, ctrl.xscroll};
            REG_MEMORY_SETUP:       rd_value = {ctrl.vm, ctrl.cb, 1'b1};
            REG_BORDER_COLOR:       rd_value = {4'hF, ctrl.ec};
            REG_BACKGROUND_COLOR_0: rd_value = {4'hF, ctrl.b0c};
            REG_BACKGROUND_COLOR_1: rd_value = {4'hF, ctrl.b1c};
            REG_BACKGROUND_COLOR_2: rd_value = {4'hF, ctrl.b2c};
            REG_BACKGROUND_COLOR_3: rd_value = {4'hF, ctrl.b3c};
            VMEM_FLAGS:             rd_value = ext_flags;
            default: ;
        endcase
    end

    // pointer block answers later through rd_valid
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dbo <= 8'hFF;
        end else if (acc.rd && !vram_owned(acc.addr)) begin
            dbo <= rd_value;
        end else if (rd_valid) begin
            dbo <= rd_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_timer #(
    parameter int DAV_OFFSET = 10
) (
    input  logic            clk_dot4x,
    input  logic            rst,
    input  logic            clk_phi,
    output vic_pkg::phase_t phase
);
    import vic_pkg::*;

    localparam int CNT_W = $clog2(HALF_CYCLES);

    logic             phi_q;
    logic             phi_edge;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cur;

    assign phi_edge = clk_phi != phi_q;
    // count is 0 on the first cycle of each half
    assign cur = phi_edge ? '0 : cnt;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_q <= 1'b0;
            cnt   <= '0;
        end else begin
            phi_q <= clk_phi;
            if (phi_edge) begin
                cnt <= CNT_W'(1);
            end else if (cnt != '1) begin
                // hold at the top if clk_phi stops
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign phase.phi_high   = clk_phi;
    assign phase.dav        = cur == CNT_W'(DAV_OFFSET);
    assign phase.dav_plus_1 = cur == CNT_W'(DAV_OFFSET + 1);
    assign phase.dav_plus_2 = cur == CNT_W'(DAV_OFFSET + 2);

endmodule

`default_nettype wire

// File: rtl/vic_pkg.sv
`default_nettype none

package vic_pkg;

    // widths and sizes
    typedef logic [5:0] reg_addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [3:0] color_t;

    localparam int VRAM_ADDR_W = 15;
    localparam int HALF_CYCLES = 16;

    // core display registers
    localparam reg_addr_t REG_SCREEN_CONTROL_1   = 6'h11;
    localparam reg_addr_t REG_SCREEN_CONTROL_2   = 6'h16;
    localparam reg_addr_t REG_MEMORY_SETUP       = 6'h18;
    localparam reg_addr_t REG_BORDER_COLOR       = 6'h20;
    localparam reg_addr_t REG_BACKGROUND_COLOR_0 = 6'h21;
    localparam reg_addr_t REG_BACKGROUND_COLOR_1 = 6'h22;
    localparam reg_addr_t REG_BACKGROUND_COLOR_2 = 6'h23;
    localparam reg_addr_t REG_BACKGROUND_COLOR_3 = 6'h24;

    // extension registers
    localparam reg_addr_t VMEM_1_IDX = 6'h35;
    localparam reg_addr_t VMEM_2_IDX = 6'h36;
    localparam reg_addr_t VMEM_1_HI  = 6'h39;
    localparam reg_addr_t VMEM_1_LO  = 6'h3A;
    localparam reg_addr_t VMEM_1_VAL = 6'h3B;
    localparam reg_addr_t VMEM_2_HI  = 6'h3C;
    localparam reg_addr_t VMEM_2_LO  = 6'h3D;
    localparam reg_addr_t VMEM_2_VAL = 6'h3E;
    localparam reg_addr_t VMEM_FLAGS = 6'h3F;

    // unlock sequence "VIC2"
    localparam byte_t KEY_V = 8'd86;
    localparam byte_t KEY_I = 8'd73;
    localparam byte_t KEY_C = 8'd67;
    localparam byte_t KEY_2 = 8'd50;

    // encoding 3 behaves like none
    typedef enum logic [1:0] {
        STEP_NONE = 2'd0,
        STEP_INC  = 2'd1,
        STEP_DEC  = 2'd2
    } step_mode_t;

    typedef struct packed {
        logic phi_high;
        logic dav;
        logic dav_plus_1;
        logic dav_plus_2;
    } phase_t;

    typedef struct packed {
        logic      rd;
        logic      wr;
        reg_addr_t addr;
        byte_t     data;
    } reg_access_t;

    typedef struct packed {
        color_t     ec;
        color_t     b0c;
        color_t     b1c;
        color_t     b2c;
        color_t     b3c;
        logic [2:0] xscroll;
        logic [2:0] yscroll;
        logic       csel;
        logic       rsel;
        logic       den;
        logic       bmm;
        logic       ecm;
        logic       mcm;
        logic       res;
        logic [2:0] cb;
        logic [3:0] vm;
    } vic_ctrl_t;

    typedef struct packed {
        logic [3:0] reserved;
        step_mode_t step2;
        step_mode_t step1;
    } ext_flags_t;

    // 0x3F data: key byte while locked, flags once unlocked
    typedef union packed {
        byte_t      key;
        ext_flags_t flags;
    } ext_flags_u;

    // addresses served by the video RAM pointer block
    function automatic logic vram_owned(input reg_addr_t addr);
        return addr inside {VMEM_1_IDX, VMEM_2_IDX, [VMEM_1_HI:VMEM_2_VAL]};
    endfunction

endpackage

`default_nettype wire

// File: rtl/vic_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module vic_register_file #(
    parameter int DAV_OFFSET  = 10,
    parameter int VRAM_ADDR_W = vic_pkg::VRAM_ADDR_W
) (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    input  logic                   clk_phi,
    input  logic                   ras,
    input  logic                   ce,
    input  logic                   rw,
    input  logic                   aec,
    input  vic_pkg::reg_addr_t     adi,
    input  vic_pkg::byte_t         dbi,
    input  logic                   raster_msb,
    output vic_pkg::byte_t         dbo,
    output vic_pkg::vic_ctrl_t     ctrl,
    input  logic [VRAM_ADDR_W-1:0] vid_addr,
    output vic_pkg::byte_t         vid_data
);
    import vic_pkg::*;

    phase_t      phase;
    reg_access_t acc;
    ext_flags_u  ext_flags;
    byte_t       rd_data;
    logic        rd_valid;

    phase_timer #(
        .DAV_OFFSET(DAV_OFFSET)
    ) u_phase_timer (
        .clk_dot4x(clk_dot4x),
        .rst      (rst),
        .clk_phi  (clk_phi),
        .phase    (phase)
    );

    bus_cycle_fsm u_bus_cycle_fsm (
        .clk_dot4x(clk_dot4x),
        .rst      (rst),
        .phase    (phase),
        .ras      (ras),
        .ce       (ce),
        .rw       (rw),
        .aec      (aec),
        .adi      (adi),
        .dbi      (dbi),
        .acc      (acc)
    );

    ctrl_regs u_ctrl_regs (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .acc       (acc),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .raster_msb(raster_msb),
        .ctrl      (ctrl),
        .ext_flags (ext_flags),
        .dbo       (dbo)
    );

    vram_port #(
        .VRAM_ADDR_W(VRAM_ADDR_W)
    ) u_vram_port (
        .clk_dot4x(clk_dot4x),
        .rst      (rst),
        .phase    (phase),
        .acc      (acc),
        .ext_flags(ext_flags),
        .vid_addr (vid_addr),
        .vid_data (vid_data),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

`default_nettype wire

// File: rtl/video_ram.sv
`timescale 1ns/1ps
`default_nettype none

module video_ram #(
    parameter int VRAM_ADDR_W = vic_pkg::VRAM_ADDR_W
) (
    input  logic                   clk_dot4x,
    input  logic                   a_we,
    input  logic [VRAM_ADDR_W-1:0] a_addr,
    input  vic_pkg::byte_t         a_wdata,
    output vic_pkg::byte_t         a_rdata,
    input  logic [VRAM_ADDR_W-1:0] b_addr,
    output vic_pkg::byte_t         b_rdata
);
    logic [7:0] mem [2**VRAM_ADDR_W];

    // cpu side, read before write
    always_ff @(posedge clk_dot4x) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];
    end

    // video fetch side never writes
    always_ff @(posedge clk_dot4x) begin
        b_rdata <= mem[b_addr];
    end

endmodule

`default_nettype wire

// File: rtl/vram_port.sv
`timescale 1ns/1ps
`default_nettype none

module vram_port #(
    parameter int VRAM_ADDR_W = vic_pkg::VRAM_ADDR_W
) (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    input  vic_pkg::phase_t        phase,
    input  vic_pkg::reg_access_t   acc,
    input  vic_pkg::ext_flags_u    ext_flags,
    input  logic [VRAM_ADDR_W-1:0] vid_addr,
    output vic_pkg::byte_t         vid_data,
    output vic_pkg::byte_t         rd_data,
    output logic                   rd_valid
);
    import vic_pkg::*;

    // per pointer {hi, lo}, so lo carries into hi for free
    logic [1:0][15:0]       ptr;
    logic [1:0][7:0]        idx;
    logic [1:0]             step_pend;
    logic [1:0]             ram_rd_pipe;
    logic                   owned;
    logic                   sel;
    logic                   is_val;
    logic [15:0]            full_addr;
    logic                   ram_we;
    logic [VRAM_ADDR_W-1:0] ram_addr;
    byte_t                  ram_wdata;
    byte_t                  ram_rdata;
    byte_t                  reg_value;

    function automatic logic [15:0] step_ptr(input logic [15:0] p, input step_mode_t mode);
        case (mode)
            STEP_INC: return p + 16'd1;
            STEP_DEC: return p - 16'd1;
            default:  return p;
        endcase
    endfunction

    assign owned     = vram_owned(acc.addr);
    // second pointer lives at 0x36 and 0x3C..0x3E
    assign sel       = acc.addr == VMEM_2_IDX || acc.addr >= VMEM_2_HI;
    assign is_val    = acc.addr == VMEM_1_VAL || acc.addr == VMEM_2_VAL;
    assign full_addr = ptr[sel] + {8'h00, idx[sel]};

    always_comb begin
        case (acc.addr)
            VMEM_1_IDX, VMEM_2_IDX: reg_value = idx[sel];
            VMEM_1_HI, VMEM_2_HI:   reg_value = ptr[sel][15:8];
            default:                reg_value = ptr[sel][7:0];
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ptr         <= '0;
            idx         <= '0;
            step_pend   <= '0;
            ram_we      <= 1'b0;
            ram_rd_pipe <= '0;
            rd_valid    <= 1'b0;
        end else begin
            ram_we      <= 1'b0;
            rd_valid    <= ram_rd_pipe[1];
            ram_rd_pipe <= {ram_rd_pipe[0], 1'b0};
            if (acc.wr && owned) begin
                case (acc.addr)
                    VMEM_1_IDX, VMEM_2_IDX: idx[sel] <= acc.data;
                    VMEM_1_HI, VMEM_2_HI:   ptr[sel][15:8] <= acc.data;
                    VMEM_1_LO, VMEM_2_LO:   ptr[sel][7:0] <= acc.data;
                    default: begin
                        ram_we         <= 1'b1;
                        step_pend[sel] <= 1'b1;
                    end
                endcase
            end
            if (acc.rd && owned) begin
                if (is_val) begin
                    ram_rd_pipe[0] <= 1'b1;
                    step_pend[sel] <= 1'b1;
                end else begin
                    rd_valid <= 1'b1;
                end
            end
            // auto step once the access half is over
            if (!phase.phi_high && phase.dav_plus_2) begin
                if (step_pend[0]) begin
                    ptr[0] <= step_ptr(ptr[0], ext_flags.flags.step1);
                end
                if (step_pend[1]) begin
                    ptr[1] <= step_ptr(ptr[1], ext_flags.flags.step2);
                end
                step_pend <= '0;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if ((acc.rd || acc.wr) && owned && is_val) begin
            ram_addr  <= full_addr[VRAM_ADDR_W-1:0];
            ram_wdata <= acc.data;
        end
        if (acc.rd && owned) begin
            rd_data <= reg_value;
        end else if (ram_rd_pipe[1]) begin
            rd_data <= ram_rdata;
        end
    end

    video_ram #(
        .VRAM_ADDR_W(VRAM_ADDR_W)
    ) u_video_ram (
        .clk_dot4x(clk_dot4x),
        .a_we     (ram_we),
        .a_addr   (ram_addr),
        .a_wdata  (ram_wdata),
        .a_rdata  (ram_rdata),
        .b_addr   (vid_addr),
        .b_rdata  (vid_data)
    );

endmodule

`default_nettype wire

// File: tb/bus_patterns.txt
# op addr data: W writes data, R expects data on dbo
# V expects data on vid_data, and its addr is a video RAM address
W 20 05
R 20 F5
W 16 1B
R 16 DB
W 18 14
R 18 15
R 2F FF
W 3F 56
W 3F 49
W 3F 58
W 3F 43
W 3F 32
W 3F 09
R 3F 00
W 3F 56
W 3F 49
W 3F 43
W 3F 32
W 3F 09
R 3F 09
W 39 12
W 3A 34
W 35 02
W 3B A5
W 3A 34
R 3B A5
V 1236 A5
W 35 00
W 39 01
W 3A FF
W 3B 11
W 3B 22
R 3A 01
R 39 02
V 01FF 11
W 3C 02
R 3E 22
R 3E 11
R 3D FE

// File: tb/tb_vic_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vic_register_file;
    import vic_pkg::*;

    localparam int PHI_HALF_CYCLES = 16;
    localparam int CLK_PERIOD_NS   = 4;
    localparam int VRAM_AW         = 15;

    logic               clk_dot4x;
    logic               rst;
    logic               clk_phi;
    logic               ras;
    logic               ce;
    logic               rw;
    logic               aec;
    reg_addr_t          adi;
    byte_t              dbi;
    logic               raster_msb;
    byte_t              dbo;
    vic_ctrl_t          ctrl;
    logic [VRAM_AW-1:0] vid_addr;
    byte_t              vid_data;

    int          phi_cnt;
    logic [31:0] lfsr;
    vic_ctrl_t   shadow;
    logic        loaded;
    logic [7:0]  op_list[$];
    logic [15:0] addr_list[$];
    byte_t       data_list[$];

    vic_register_file #(
        .DAV_OFFSET (10),
        .VRAM_ADDR_W(VRAM_AW)
    ) u_vic_register_file (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .clk_phi   (clk_phi),
        .ras       (ras),
        .ce        (ce),
        .rw        (rw),
        .aec       (aec),
        .adi       (adi),
        .dbi       (dbi),
        .raster_msb(raster_msb),
        .dbo       (dbo),
        .ctrl      (ctrl),
        .vid_addr  (vid_addr),
        .vid_data  (vid_data)
    );

    always #(CLK_PERIOD_NS / 2) clk_dot4x = ~clk_dot4x;

    // phi toggles every PHI_HALF_CYCLES dot clocks
    always @(posedge clk_dot4x) begin
        if (phi_cnt == PHI_HALF_CYCLES - 1) begin
            phi_cnt <= 0;
            clk_phi <= ~clk_phi;
        end else begin
            phi_cnt <= phi_cnt + 1;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_idle_count(output int n);
        n = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            n = (n << 1) | lfsr[0];
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        assert (got === exp)
            else report_mismatch($sformatf("%s read %02h, expected %02h", what, got, exp));
    endtask

    task automatic check_ctrl();
        assert (ctrl === shadow)
            else report_mismatch($sformatf("ctrl is %010h, expected %010h", ctrl, shadow));
    endtask

    // expected ctrl fields from the register map
    task automatic update_shadow(input reg_addr_t a, input byte_t d);
        case (a)
            REG_SCREEN_CONTROL_1: begin
                shadow.yscroll = d[2:0];
                shadow.rsel    = d[3];
                shadow.den     = d[4];
                shadow.bmm     = d[5];
                shadow.ecm     = d[6];
            end
            REG_SCREEN_CONTROL_2: begin
                shadow.xscroll = d[2:0];
                shadow.csel    = d[3];
                shadow.mcm     = d[4];
                shadow.res     = d[5];
            end
            REG_MEMORY_SETUP: begin
                shadow.cb = d[3:1];
                shadow.vm = d[7:4];
            end
            REG_BORDER_COLOR:       shadow.ec  = d[3:0];
            REG_BACKGROUND_COLOR_0: shadow.b0c = d[3:0];
            REG_BACKGROUND_COLOR_1: shadow.b1c = d[3:0];
            REG_BACKGROUND_COLOR_2: shadow.b2c = d[3:0];
            REG_BACKGROUND_COLOR_3: shadow.b3c = d[3:0];
            default: ;
        endcase
    endtask

    // one full phi period with the access in the high half
    task automatic bus_period(input logic is_read, input reg_addr_t a, input byte_t d);
        do begin
            @(posedge clk_dot4x);
        end while (!(phi_cnt == PHI_HALF_CYCLES - 1 && !clk_phi));
        ras <= 1'b0;
        ce  <= 1'b0;
        rw  <= is_read;
        adi <= a;
        dbi <= is_read ? 8'h00 : d;
        repeat (PHI_HALF_CYCLES - 1) @(posedge clk_dot4x);
        // last cycle of the high half
        @(negedge clk_dot4x);
        if (is_read) begin
            check_byte($sformatf("register %02h", a), dbo, d);
        end
        @(posedge clk_dot4x);
        ras <= 1'b1;
        ce  <= 1'b1;
        rw  <= 1'b1;
        repeat (PHI_HALF_CYCLES - 1) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        check_ctrl();
    endtask

    task automatic video_check(input logic [15:0] a, input byte_t exp);
        @(posedge clk_dot4x);
        vid_addr <= a[VRAM_AW-1:0];
        @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        check_byte($sformatf("video address %04h", a), vid_data, exp);
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] a;
        logic [7:0]  d;
        fd = $fopen("tb/bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tb/bus_patterns.txt");
            $display("*** TEST FAILED ***");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h", op, a, d);
            if (n == 3 && op != "#") begin
                op_list.push_back(op);
                addr_list.push_back(a);
                data_list.push_back(d);
            end
        end
        $fclose(fd);
        if (op_list.size() == 0) begin
            $display("the pattern file tb/bus_patterns.txt holds no bus operations");
            $display("*** TEST FAILED ***");
            $fatal(1, "empty stimulus");
        end
    endtask

    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = (op_list.size() * 4 + 10) * 2 * PHI_HALF_CYCLES * CLK_PERIOD_NS;
        #(limit_ns);
        $display("timeout: pattern playback did not finish within %0d ns", limit_ns);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int idle;
        clk_dot4x  = 1'b0;
        rst        = 1'b1;
        clk_phi    = 1'b0;
        phi_cnt    = 0;
        ras        = 1'b1;
        ce         = 1'b1;
        rw         = 1'b1;
        aec        = 1'b1;
        adi        = '0;
        dbi        = '0;
        raster_msb = 1'b0;
        vid_addr   = '0;
        lfsr       = 32'h50309d45;
        shadow     = '0;
        loaded     = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk_dot4x);
        rst <= 1'b0;
        foreach (op_list[i]) begin
            case (op_list[i])
                "W": begin
                    update_shadow(addr_list[i][5:0], data_list[i]);
                    bus_period(1'b0, addr_list[i][5:0], data_list[i]);
                end
                "R":     bus_period(1'b1, addr_list[i][5:0], data_list[i]);
                "V":     video_check(addr_list[i], data_list[i]);
                default: begin
                    $display("unknown operation '%c' in the pattern file", op_list[i]);
                    $display("*** TEST FAILED ***");
                    $fatal(1, "bad pattern line");
                end
            endcase
            pick_idle_count(idle);
            repeat (idle * 2 * PHI_HALF_CYCLES) @(posedge clk_dot4x);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/vic_register_file_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vic_register_file_checker (
    input logic                 clk_dot4x,
    input logic                 rst,
    input vic_pkg::phase_t      phase,
    input vic_pkg::reg_access_t acc
);
    // set by the first read of a phi-high half
    logic rd_seen;

    always_ff @(posedge clk_dot4x) begin
        if (rst || !phase.phi_high) begin
            rd_seen <= 1'b0;
        end else if (acc.rd) begin
            rd_seen <= 1'b1;
        end
    end

    assert property (@(posedge clk_dot4x) disable iff (rst) !(acc.rd && acc.wr))
        else $error("read and write requested in the same cycle");

    // writes only on the data-valid strobe of the high half
    assert property (@(posedge clk_dot4x) disable iff (rst)
        acc.wr |-> (phase.dav && phase.phi_high))
        else $error("write request outside the high-half dav strobe");

    assert property (@(posedge clk_dot4x) disable iff (rst) !(acc.rd && rd_seen))
        else $error("second read request in one phi-high half");

endmodule

bind bus_cycle_fsm vic_register_file_checker u_checker (
    .clk_dot4x(clk_dot4x),
    .rst      (rst),
    .phase    (phase),
    .acc      (acc)
);

`default_nettype wire

// File: vlog.f
rtl/vic_pkg.sv
rtl/phase_timer.sv
rtl/bus_cycle_fsm.sv
rtl/ctrl_regs.sv
rtl/video_ram.sv
rtl/vram_port.sv
rtl/vic_register_file.sv
tb/vic_register_file_checker.sv
tb/tb_vic_register_file.sv
